// ==== issue_stage.f ====
issue_pkg.sv
operand_resolve.sv
issue_control.sv
issue_slot.sv
issue_stage.sv
issue_stage_sva.sv
tb_issue_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_issue_stage
FILELIST  = issue_stage.f
OBJDIR    = obj_dir
LOG       = sim.log
RUNFLAGS  = +verilator+error+limit+1000
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_issue_stage.sv ====
`timescale 1ns/10ps

module tb_issue_stage;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS = 25;
    localparam int NUM_COLS = 19;

    // Operand source codes for the expected value columns
    localparam int S_RF   = 0;
    localparam int S_WBB  = 1;
    localparam int S_IPW  = 2;
    localparam int S_IPF  = 3;
    localparam int S_LSPW = 4;
    localparam int S_PC   = 5;
    localparam int S_IMM  = 6;
    localparam int S_FOUR = 7;
    localparam int S_ZIMM = 8;
    localparam int S_ZERO = 9;

    localparam int T_IP  = 1;
    localparam int T_LSP = 2;

    logic clk, rst, pipe_flush, dec_valid, dec_ready;
    logic dec_option, dec_truncate, dec_wb_en, dec_mem_sign;
    logic [3:0] dec_op;
    logic [1:0] dec_mem_width;
    issue_pkg::op_type_t dec_op_type;
    issue_pkg::opr1_sel_t dec_operand1;
    issue_pkg::opr2_sel_t dec_operand2;
    issue_pkg::xdata_t dec_pc, dec_imm, rf_rdata0, rf_rdata1;
    issue_pkg::reg_idx_t dec_rs1, dec_rs2, dec_rd, rf_rsrc0, rf_rsrc1;
    logic wb_buf_valid, ip_wb_valid, ip_wb_wb_en, lsp_wb_valid, lsp_wb_wb_en, lsp_mem_wb_en;
    issue_pkg::reg_idx_t wb_buf_dst, ip_wb_dst, lsp_wb_dst, lsp_mem_dst;
    issue_pkg::xdata_t wb_buf_value, ip_wb_result, ip_forwarding, lsp_wb_result;
    logic ip_valid, ip_ready, ip_wb_en, ip_option, ip_truncate;
    logic [3:0] ip_op;
    issue_pkg::reg_idx_t ip_dst, lsp_dst;
    issue_pkg::xdata_t ip_pc, ip_operand1, ip_operand2, lsp_pc, lsp_base, lsp_source;
    logic lsp_valid, lsp_ready, lsp_wb_en, lsp_mem_sign;
    logic [1:0] lsp_mem_width;
    logic [issue_pkg::LSP_OFFSET_W-1:0] lsp_offset;

    integer seed;
    int mismatches = 0;
    int cur_row = -1;
    logic prev_stalled = 1'b0;
    logic exp_ip_valid = 1'b0;
    logic exp_lsp_valid = 1'b0;
    issue_pkg::ip_req_t exp_ip;
    issue_pkg::lsp_req_t exp_lsp;

    // v ot o1 o2 rs1 rs2 rd we | wbb ipw lspw mem dst (-1 idle) | ipr lspr fl | rdy tgt s1 s2
    // ot 0 INT 1 LOAD 2 STORE, o1 0 RS1 1 PC 2 ZERO 3 ZIMM, o2 0 RS2 1 IMM 2 FOUR
    int rows [NUM_ROWS][NUM_COLS] = '{
        '{1, 0, 1, 1,  3,  4,  5, 1,  -1, -1, -1, -1,  1, 1, 0,  1, 1, 5, 6},
        '{1, 0, 3, 2, 17,  0,  6, 1,  -1, -1, -1, -1,  1, 1, 0,  1, 1, 8, 7},
        '{1, 0, 2, 0,  1,  9,  7, 1,  -1, -1, -1, -1,  1, 1, 0,  1, 1, 9, 0},
        '{1, 0, 0, 0,  7,  8,  8, 1,   7,  7,  8, -1,  1, 1, 0,  1, 1, 3, 4},
        '{1, 0, 0, 0,  8, 10,  9, 1,  10, 10,  8, -1,  1, 1, 0,  1, 1, 4, 2},
        '{1, 0, 0, 0,  0,  0,  0, 0,   0,  0,  0,  0,  1, 1, 0,  1, 1, 9, 9},
        '{1, 0, 0, 0, 12, 13, 11, 1,  12, -1, -1, -1,  1, 1, 0,  1, 1, 1, 0},
        '{1, 1, 0, 1, 11,  0, 14, 1,  -1, -1, -1, -1,  0, 1, 0,  0, 0, 0, 0},
        '{1, 1, 0, 1, 11,  0, 14, 1,  -1, -1, -1, -1,  1, 1, 0,  1, 2, 3, 6},
        '{1, 0, 0, 1, 14,  0, 15, 1,  -1, -1, -1, -1,  1, 0, 0,  0, 0, 0, 0},
        '{1, 0, 0, 1, 14,  0, 15, 1,  -1, -1, -1, -1,  1, 1, 0,  0, 0, 0, 0},
        '{1, 0, 0, 1, 14,  0, 15, 1,  -1, -1, 14, -1,  1, 1, 0,  1, 1, 4, 6},
        '{1, 0, 0, 0,  3, 20, 16, 1,  -1, -1, -1, 20,  1, 1, 0,  0, 0, 0, 0},
        '{1, 0, 0, 0,  3, 20, 16, 1,  -1, -1, -1, -1,  1, 1, 0,  1, 1, 0, 0},
        '{1, 0, 1, 1,  3,  4, 21, 1,  -1, -1, -1, 21,  1, 1, 0,  0, 0, 0, 0},
        '{1, 1, 0, 1,  2,  0, 21, 1,  -1, -1, -1, 21,  1, 1, 0,  1, 2, 0, 6},
        '{1, 0, 1, 1,  3,  4, 21, 1,  -1, -1, -1, -1,  1, 0, 0,  0, 0, 0, 0},
        '{1, 0, 1, 2,  3,  4, 21, 0,  -1, -1, -1, -1,  1, 0, 0,  1, 1, 5, 7},
        '{1, 2, 0, 0,  5,  6,  0, 0,  -1, -1, -1, -1,  0, 0, 0,  0, 0, 0, 0},
        '{1, 0, 1, 1,  3,  4, 22, 1,  -1, -1, -1, -1,  0, 0, 0,  0, 0, 0, 0},
        '{1, 2, 0, 0,  5,  6,  0, 0,  -1, -1, -1, -1,  0, 0, 1,  1, 0, 0, 0},
        '{1, 2, 0, 0,  5,  6,  0, 0,  -1, -1, -1, -1,  1, 1, 0,  1, 2, 0, 0},
        '{0, 0, 0, 0,  0,  0,  0, 0,  -1, -1, -1, -1,  1, 1, 0,  1, 0, 0, 0},
        '{1, 3, 1, 1,  0,  0,  1, 0,  -1, -1, -1, -1,  1, 1, 0,  0, 0, 0, 0},
        '{1, 2, 1, 1,  0,  0,  0, 0,  -1, -1, -1, -1,  1, 1, 1,  1, 0, 0, 0}
    };

    issue_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic issue_pkg::xdata_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Expected operand value for a source code
    function automatic issue_pkg::xdata_t source_value(int code, issue_pkg::xdata_t rf_word);
        case (code)
            S_RF:    return rf_word;
            S_WBB:   return wb_buf_value;
            S_IPW:   return ip_wb_result;
            S_IPF:   return ip_forwarding;
            S_LSPW:  return lsp_wb_result;
            S_PC:    return dec_pc;
            S_IMM:   return dec_imm;
            S_FOUR:  return 64'd4;
            S_ZIMM:  return {59'd0, dec_rs1};
            default: return '0;
        endcase
    endfunction

    task automatic check_data(input issue_pkg::xdata_t got, input issue_pkg::xdata_t want,
                              input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: row %0d %s got %h expected %h",
                     $time, cur_row, what, got, want);
            mismatches++;
        end
    endtask

    task automatic check_idx(input issue_pkg::reg_idx_t got, input issue_pkg::reg_idx_t want,
                             input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: row %0d %s got %0d expected %0d",
                     $time, cur_row, what, got, want);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: row %0d %s got %b expected %b",
                     $time, cur_row, what, got, want);
            mismatches++;
        end
    endtask

    task automatic check_slots();
        check_flag(ip_valid, exp_ip_valid, "ip_valid");
        if (exp_ip_valid) begin
            check_data(ip_pc, exp_ip.pc, "ip_pc");
            check_idx(ip_dst, exp_ip.dst, "ip_dst");
            check_flag(ip_wb_en, exp_ip.wb_en, "ip_wb_en");
            check_data(issue_pkg::xdata_t'(ip_op), issue_pkg::xdata_t'(exp_ip.op), "ip_op");
            check_flag(ip_option, exp_ip.option, "ip_option");
            check_flag(ip_truncate, exp_ip.truncate, "ip_truncate");
            check_data(ip_operand1, exp_ip.operand1, "ip_operand1");
            check_data(ip_operand2, exp_ip.operand2, "ip_operand2");
        end
        check_flag(lsp_valid, exp_lsp_valid, "lsp_valid");
        if (exp_lsp_valid) begin
            check_data(lsp_pc, exp_lsp.pc, "lsp_pc");
            check_idx(lsp_dst, exp_lsp.dst, "lsp_dst");
            check_flag(lsp_wb_en, exp_lsp.wb_en, "lsp_wb_en");
            check_data(lsp_base, exp_lsp.base, "lsp_base");
            check_data(issue_pkg::xdata_t'(lsp_offset), issue_pkg::xdata_t'(exp_lsp.offset),
                       "lsp_offset");
            check_data(lsp_source, exp_lsp.source, "lsp_source");
            check_flag(lsp_mem_sign, exp_lsp.mem_sign, "lsp_mem_sign");
            check_data(issue_pkg::xdata_t'(lsp_mem_width),
                       issue_pkg::xdata_t'(exp_lsp.mem_width), "lsp_mem_width");
        end
    endtask

    task automatic apply_row(input int i);
        logic [31:0] misc;
        // Decoder fields stay put while the previous instruction is stalled
        if (!prev_stalled) begin
            dec_pc = rand64();
            dec_imm = rand64();
            misc = $random(seed);
            dec_op = misc[3:0];
            dec_option = misc[4];
            dec_truncate = misc[5];
            dec_mem_sign = misc[6];
            dec_mem_width = misc[8:7];
        end
        dec_valid = (rows[i][0] != 0);
        dec_op_type = issue_pkg::op_type_t'(3'(rows[i][1]));
        dec_operand1 = issue_pkg::opr1_sel_t'(2'(rows[i][2]));
        dec_operand2 = issue_pkg::opr2_sel_t'(2'(rows[i][3]));
        dec_rs1 = issue_pkg::reg_idx_t'(rows[i][4]);
        dec_rs2 = issue_pkg::reg_idx_t'(rows[i][5]);
        dec_rd = issue_pkg::reg_idx_t'(rows[i][6]);
        dec_wb_en = (rows[i][7] != 0);
        rf_rdata0 = rand64();
        rf_rdata1 = rand64();
        wb_buf_value = rand64();
        ip_wb_result = rand64();
        ip_forwarding = rand64();
        lsp_wb_result = rand64();
        wb_buf_valid = (rows[i][8] >= 0);
        wb_buf_dst = issue_pkg::reg_idx_t'(rows[i][8]);
        ip_wb_valid = (rows[i][9] >= 0);
        ip_wb_wb_en = (rows[i][9] >= 0);
        ip_wb_dst = issue_pkg::reg_idx_t'(rows[i][9]);
        lsp_wb_valid = (rows[i][10] >= 0);
        lsp_wb_wb_en = (rows[i][10] >= 0);
        lsp_wb_dst = issue_pkg::reg_idx_t'(rows[i][10]);
        lsp_mem_wb_en = (rows[i][11] >= 0);
        lsp_mem_dst = issue_pkg::reg_idx_t'(rows[i][11]);
        ip_ready = (rows[i][12] != 0);
        lsp_ready = (rows[i][13] != 0);
        pipe_flush = (rows[i][14] != 0);
    endtask

    // Slot contents expected after the coming edge
    task automatic update_model(input int i);
        issue_pkg::xdata_t opr1;
        issue_pkg::xdata_t opr2;
        opr1 = source_value(rows[i][17], rf_rdata0);
        opr2 = source_value(rows[i][18], rf_rdata1);
        if (rows[i][16] == T_IP) begin
            exp_ip_valid = 1'b1;
            exp_ip.pc = dec_pc;
            exp_ip.dst = dec_rd;
            exp_ip.wb_en = dec_wb_en;
            exp_ip.op = dec_op;
            exp_ip.option = dec_option;
            exp_ip.truncate = dec_truncate;
            exp_ip.operand1 = opr1;
            exp_ip.operand2 = opr2;
        end else if (ip_ready || pipe_flush) begin
            exp_ip_valid = 1'b0;
        end
        if (rows[i][16] == T_LSP) begin
            exp_lsp_valid = 1'b1;
            exp_lsp.pc = dec_pc;
            exp_lsp.dst = dec_rd;
            exp_lsp.wb_en = dec_wb_en;
            exp_lsp.base = opr1;
            exp_lsp.offset = dec_imm[issue_pkg::LSP_OFFSET_W-1:0];
            exp_lsp.source = opr2;
            exp_lsp.mem_sign = dec_mem_sign;
            exp_lsp.mem_width = dec_mem_width;
        end else if (lsp_ready || pipe_flush) begin
            exp_lsp_valid = 1'b0;
        end
    endtask

    initial begin
        int asserts;
        seed = 7;
        rst = 1'b1;
        prev_stalled = 1'b0;
        // An instruction offered during reset must not reach a slot
        apply_row(0);
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        dec_valid = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #1;
            cur_row = i;
            apply_row(i);
            @(negedge clk);
            check_flag(dec_ready, rows[i][15] != 0, "dec_ready");
            check_idx(rf_rsrc0, dec_rs1, "rf_rsrc0");
            check_idx(rf_rsrc1, dec_rs2, "rf_rsrc1");
            check_slots();
            update_model(i);
            prev_stalled = (rows[i][0] != 0) && (rows[i][15] == 0);
        end
        @(posedge clk);
        @(negedge clk);
        cur_row = NUM_ROWS;
        check_slots();
        asserts = DUT.u_sva.fail_count;
        $display("errors: %0d mismatches, %0d assertion failures", mismatches, asserts);
        if (mismatches == 0 && asserts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_ROWS * 20) @(posedge clk);
        $display("Timeout: the table did not finish within %0d cycles", NUM_ROWS * 20);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== issue_stage_sva.sv ====
`timescale 1ns/10ps

module issue_stage_sva (
    input logic                clk,
    input logic                rst,
    input logic                pipe_flush,
    input logic                dec_ready,
    input logic                issue_ip,
    input logic                issue_lsp,
    input logic                ip_valid,
    input logic                ip_ready,
    input issue_pkg::xdata_t   ip_pc,
    input issue_pkg::reg_idx_t ip_dst,
    input issue_pkg::xdata_t   ip_operand1,
    input issue_pkg::xdata_t   ip_operand2,
    input logic                lsp_valid,
    input logic                lsp_ready,
    input issue_pkg::xdata_t   lsp_pc,
    input issue_pkg::reg_idx_t lsp_dst,
    input issue_pkg::xdata_t   lsp_base,
    input issue_pkg::xdata_t   lsp_source
);

    int fail_count = 0;

    // A stalled slot holds its request unless flushed
    assert property (@(posedge clk) disable iff (rst)
        ip_valid && !ip_ready && !pipe_flush |=>
            ip_valid && $stable({ip_pc, ip_dst, ip_operand1, ip_operand2}))
    else begin
        $error("integer slot changed while ready was low");
        fail_count = fail_count + 1;
    end

    assert property (@(posedge clk) disable iff (rst)
        lsp_valid && !lsp_ready && !pipe_flush |=>
            lsp_valid && $stable({lsp_pc, lsp_dst, lsp_base, lsp_source}))
    else begin
        $error("load/store slot changed while ready was low");
        fail_count = fail_count + 1;
    end

    assert property (@(posedge clk) rst |=> !ip_valid && !lsp_valid)
    else begin
        $error("slot valid set after reset");
        fail_count = fail_count + 1;
    end

    assert property (@(posedge clk) pipe_flush |-> !issue_ip && !issue_lsp)
    else begin
        $error("issue during flush");
        fail_count = fail_count + 1;
    end

    assert property (@(posedge clk) rst |-> !dec_ready)
    else begin
        $error("dec_ready high during reset");
        fail_count = fail_count + 1;
    end

endmodule

bind issue_stage issue_stage_sva u_sva (
    .clk(clk), .rst(rst), .pipe_flush(pipe_flush), .dec_ready(dec_ready),
    .issue_ip(issue_ip), .issue_lsp(issue_lsp),
    .ip_valid(ip_valid), .ip_ready(ip_ready), .ip_pc(ip_pc), .ip_dst(ip_dst),
    .ip_operand1(ip_operand1), .ip_operand2(ip_operand2),
    .lsp_valid(lsp_valid), .lsp_ready(lsp_ready), .lsp_pc(lsp_pc), .lsp_dst(lsp_dst),
    .lsp_base(lsp_base), .lsp_source(lsp_source)
);

// ==== issue_stage.sv ====
`timescale 1ns/10ps

module issue_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pipe_flush,
    // Decoder
    input  issue_pkg::xdata_t                    dec_pc,
    input  logic [3:0]                           dec_op,
    input  logic                                 dec_option,
    input  logic                                 dec_truncate,
    input  issue_pkg::op_type_t                  dec_op_type,
    input  issue_pkg::opr1_sel_t                 dec_operand1,
    input  issue_pkg::opr2_sel_t                 dec_operand2,
    input  issue_pkg::xdata_t                    dec_imm,
    input  issue_pkg::reg_idx_t                  dec_rs1,
    input  issue_pkg::reg_idx_t                  dec_rs2,
    input  issue_pkg::reg_idx_t                  dec_rd,
    input  logic                                 dec_wb_en,
    input  logic                                 dec_mem_sign,
    input  logic [1:0]                           dec_mem_width,
    input  logic                                 dec_valid,
    output logic                                 dec_ready,
    // Register file
    output issue_pkg::reg_idx_t                  rf_rsrc0,
    input  issue_pkg::xdata_t                    rf_rdata0,
    output issue_pkg::reg_idx_t                  rf_rsrc1,
    input  issue_pkg::xdata_t                    rf_rdata1,
    // Forwarding and stall points
    input  logic                                 wb_buf_valid,
    input  issue_pkg::reg_idx_t                  wb_buf_dst,
    input  issue_pkg::xdata_t                    wb_buf_value,
    input  logic                                 ip_wb_valid,
    input  logic                                 ip_wb_wb_en,
    input  issue_pkg::reg_idx_t                  ip_wb_dst,
    input  issue_pkg::xdata_t                    ip_wb_result,
    input  issue_pkg::xdata_t                    ip_forwarding,
    input  logic                                 lsp_wb_valid,
    input  logic                                 lsp_wb_wb_en,
    input  issue_pkg::reg_idx_t                  lsp_wb_dst,
    input  issue_pkg::xdata_t                    lsp_wb_result,
    input  logic                                 lsp_mem_wb_en,
    input  issue_pkg::reg_idx_t                  lsp_mem_dst,
    // Integer pipe
    output logic                                 ip_valid,
    input  logic                                 ip_ready,
    output issue_pkg::xdata_t                    ip_pc,
    output issue_pkg::reg_idx_t                  ip_dst,
    output logic                                 ip_wb_en,
    output logic [3:0]                           ip_op,
    output logic                                 ip_option,
    output logic                                 ip_truncate,
    output issue_pkg::xdata_t                    ip_operand1,
    output issue_pkg::xdata_t                    ip_operand2,
    // Load/store pipe
    output logic                                 lsp_valid,
    input  logic                                 lsp_ready,
    output issue_pkg::xdata_t                    lsp_pc,
    output issue_pkg::reg_idx_t                  lsp_dst,
    output logic                                 lsp_wb_en,
    output issue_pkg::xdata_t                    lsp_base,
    output logic [issue_pkg::LSP_OFFSET_W-1:0]   lsp_offset,
    output issue_pkg::xdata_t                    lsp_source,
    output logic                                 lsp_mem_sign,
    output logic [1:0]                           lsp_mem_width
);

    issue_pkg::xdata_t    rs1_value;
    issue_pkg::xdata_t    rs2_value;
    logic                 rs1_ready;
    logic                 rs2_ready;
    issue_pkg::xdata_t    operand1;
    issue_pkg::xdata_t    operand2;
    logic                 issue_ip;
    logic                 issue_lsp;
    issue_pkg::ip_req_t   ip_req_in;
    issue_pkg::ip_req_t   ip_req;
    issue_pkg::lsp_req_t  lsp_req_in;
    issue_pkg::lsp_req_t  lsp_req;

    // Register file is read with the raw source fields
    assign rf_rsrc0 = dec_rs1;
    assign rf_rsrc1 = dec_rs2;

    operand_resolve u_rs1 (
        .rsrc(dec_rs1), .rdata(rf_rdata0),
        .wb_buf_valid(wb_buf_valid), .wb_buf_dst(wb_buf_dst), .wb_buf_value(wb_buf_value),
        .ip_wb_valid(ip_wb_valid), .ip_wb_wb_en(ip_wb_wb_en),
        .ip_wb_dst(ip_wb_dst), .ip_wb_result(ip_wb_result), .ip_forwarding(ip_forwarding),
        .lsp_wb_valid(lsp_wb_valid), .lsp_wb_wb_en(lsp_wb_wb_en),
        .lsp_wb_dst(lsp_wb_dst), .lsp_wb_result(lsp_wb_result),
        .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
        .ip_valid(ip_valid), .ip_ready(ip_ready), .ip_wb_en(ip_wb_en), .ip_dst(ip_dst),
        .lsp_valid(lsp_valid), .lsp_wb_en(lsp_wb_en), .lsp_dst(lsp_dst),
        .value(rs1_value), .ready(rs1_ready)
    );

    operand_resolve u_rs2 (
        .rsrc(dec_rs2), .rdata(rf_rdata1),
        .wb_buf_valid(wb_buf_valid), .wb_buf_dst(wb_buf_dst), .wb_buf_value(wb_buf_value),
        .ip_wb_valid(ip_wb_valid), .ip_wb_wb_en(ip_wb_wb_en),
        .ip_wb_dst(ip_wb_dst), .ip_wb_result(ip_wb_result), .ip_forwarding(ip_forwarding),
        .lsp_wb_valid(lsp_wb_valid), .lsp_wb_wb_en(lsp_wb_wb_en),
        .lsp_wb_dst(lsp_wb_dst), .lsp_wb_result(lsp_wb_result),
        .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
        .ip_valid(ip_valid), .ip_ready(ip_ready), .ip_wb_en(ip_wb_en), .ip_dst(ip_dst),
        .lsp_valid(lsp_valid), .lsp_wb_en(lsp_wb_en), .lsp_dst(lsp_dst),
        .value(rs2_value), .ready(rs2_ready)
    );

    issue_control u_ctrl (
        .rst(rst), .dec_valid(dec_valid), .pipe_flush(pipe_flush),
        .dec_op_type(dec_op_type), .dec_operand1(dec_operand1), .dec_operand2(dec_operand2),
        .dec_pc(dec_pc), .dec_imm(dec_imm), .dec_rs1(dec_rs1), .dec_rd(dec_rd),
        .dec_wb_en(dec_wb_en),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .ip_ready(ip_ready), .lsp_ready(lsp_ready), .lsp_valid(lsp_valid),
        .lsp_wb_en(lsp_wb_en), .lsp_mem_wb_en(lsp_mem_wb_en),
        .lsp_dst(lsp_dst), .lsp_mem_dst(lsp_mem_dst),
        .operand1(operand1), .operand2(operand2),
        .issue_ip(issue_ip), .issue_lsp(issue_lsp), .dec_ready(dec_ready)
    );

    // Pack requests
    assign ip_req_in = '{pc: dec_pc, dst: dec_rd, wb_en: dec_wb_en, op: dec_op,
                         option: dec_option, truncate: dec_truncate,
                         operand1: operand1, operand2: operand2};

    // Load/store base and store data come from the operand muxes
    assign lsp_req_in = '{pc: dec_pc, dst: dec_rd, wb_en: dec_wb_en, base: operand1,
                          offset: dec_imm[issue_pkg::LSP_OFFSET_W-1:0], source: operand2,
                          mem_sign: dec_mem_sign, mem_width: dec_mem_width};

    issue_slot #(.payload_t(issue_pkg::ip_req_t)) u_ip_slot (
        .clk(clk), .rst(rst), .flush(pipe_flush), .issue(issue_ip),
        .payload_in(ip_req_in), .ready(ip_ready), .valid(ip_valid), .payload(ip_req)
    );

    issue_slot #(.payload_t(issue_pkg::lsp_req_t)) u_lsp_slot (
        .clk(clk), .rst(rst), .flush(pipe_flush), .issue(issue_lsp),
        .payload_in(lsp_req_in), .ready(lsp_ready), .valid(lsp_valid), .payload(lsp_req)
    );

    // Unpack slot contents
    assign ip_pc       = ip_req.pc;
    assign ip_dst      = ip_req.dst;
    assign ip_wb_en    = ip_req.wb_en;
    assign ip_op       = ip_req.op;
    assign ip_option   = ip_req.option;
    assign ip_truncate = ip_req.truncate;
    assign ip_operand1 = ip_req.operand1;
    assign ip_operand2 = ip_req.operand2;

    assign lsp_pc        = lsp_req.pc;
    assign lsp_dst       = lsp_req.dst;
    assign lsp_wb_en     = lsp_req.wb_en;
    assign lsp_base      = lsp_req.base;
    assign lsp_offset    = lsp_req.offset;
    assign lsp_source    = lsp_req.source;
    assign lsp_mem_sign  = lsp_req.mem_sign;
    assign lsp_mem_width = lsp_req.mem_width;

endmodule

// ==== issue_slot.sv ====
`timescale 1ns/10ps

module issue_slot #(
    parameter type payload_t = logic [63:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     issue,
    input  payload_t payload_in,
    input  logic     ready,
    output logic     valid,
    output payload_t payload
);

    // Issue takes priority over release and flush
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (issue) begin
            valid <= 1'b1;
        end else if (ready || flush) begin
            valid <= 1'b0;
        end
    end

    // Payload only moves on issue, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (issue) begin
            payload <= payload_in;
        end
    end

endmodule

// ==== issue_control.sv ====
`timescale 1ns/10ps

module issue_control (
    input  logic                 rst,
    input  logic                 dec_valid,
    input  logic                 pipe_flush,
    input  issue_pkg::op_type_t  dec_op_type,
    input  issue_pkg::opr1_sel_t dec_operand1,
    input  issue_pkg::opr2_sel_t dec_operand2,
    input  issue_pkg::xdata_t    dec_pc,
    input  issue_pkg::xdata_t    dec_imm,
    input  issue_pkg::reg_idx_t  dec_rs1,
    input  issue_pkg::reg_idx_t  dec_rd,
    input  logic                 dec_wb_en,
    // Resolved sources
    input  issue_pkg::xdata_t    rs1_value,
    input  issue_pkg::xdata_t    rs2_value,
    input  logic                 rs1_ready,
    input  logic                 rs2_ready,
    // Downstream state
    input  logic                 ip_ready,
    input  logic                 lsp_ready,
    input  logic                 lsp_valid,
    input  logic                 lsp_wb_en,
    input  logic                 lsp_mem_wb_en,
    input  issue_pkg::reg_idx_t  lsp_dst,
    input  issue_pkg::reg_idx_t  lsp_mem_dst,
    output issue_pkg::xdata_t    operand1,
    output issue_pkg::xdata_t    operand2,
    output logic                 issue_ip,
    output logic                 issue_lsp,
    output logic                 dec_ready
);

    logic opr1_ready;
    logic opr2_ready;
    logic is_int;
    logic is_lsp;
    logic waw_mem;
    logic waw_ag;
    logic waw_ok;
    logic issue_common;

    // Operand 1 mux
    always_comb begin
        case (dec_operand1)
            issue_pkg::OPR1_RS1:  operand1 = rs1_value;
            issue_pkg::OPR1_PC:   operand1 = dec_pc;
            issue_pkg::OPR1_ZERO: operand1 = '0;
            issue_pkg::OPR1_ZIMM: operand1 = {{(issue_pkg::XLEN-issue_pkg::REG_W){1'b0}}, dec_rs1};
            default:              operand1 = '0;
        endcase
    end

    // Operand 2 mux
    always_comb begin
        case (dec_operand2)
            issue_pkg::OPR2_RS2:  operand2 = rs2_value;
            issue_pkg::OPR2_IMM:  operand2 = dec_imm;
            issue_pkg::OPR2_FOUR: operand2 = issue_pkg::XLEN'(4);
            default:              operand2 = '0;
        endcase
    end

    // Only register operands can hold up issue
    assign opr1_ready = (dec_operand1 != issue_pkg::OPR1_RS1) || rs1_ready;
    assign opr2_ready = (dec_operand2 != issue_pkg::OPR2_RS2) || rs2_ready;

    assign is_int = (dec_op_type == issue_pkg::OT_INT);
    assign is_lsp = (dec_op_type == issue_pkg::OT_LOAD) ||
                    (dec_op_type == issue_pkg::OT_STORE);

    // A fast integer result must not land before an older load to the same rd
    assign waw_mem = lsp_mem_wb_en && (lsp_mem_dst == dec_rd);
    assign waw_ag  = lsp_valid && lsp_wb_en && (lsp_dst == dec_rd);
    assign waw_ok  = !dec_wb_en || !(waw_mem || waw_ag);

    assign issue_common = dec_valid && !pipe_flush && opr1_ready && opr2_ready;

    assign issue_ip  = issue_common && is_int && waw_ok && ip_ready;
    assign issue_lsp = issue_common && is_lsp && lsp_ready;

    // Flush drains the decoder, otherwise hold until something issues
    assign dec_ready = !rst && (!dec_valid || pipe_flush || issue_ip || issue_lsp);

endmodule

// ==== operand_resolve.sv ====
`timescale 1ns/10ps

module operand_resolve (
    input  issue_pkg::reg_idx_t rsrc,
    input  issue_pkg::xdata_t   rdata,
    // Writeback buffer
    input  logic                wb_buf_valid,
    input  issue_pkg::reg_idx_t wb_buf_dst,
    input  issue_pkg::xdata_t   wb_buf_value,
    // Integer pipe writeback and execute
    input  logic                ip_wb_valid,
    input  logic                ip_wb_wb_en,
    input  issue_pkg::reg_idx_t ip_wb_dst,
    input  issue_pkg::xdata_t   ip_wb_result,
    input  issue_pkg::xdata_t   ip_forwarding,
    // Load/store pipe writeback and memory access
    input  logic                lsp_wb_valid,
    input  logic                lsp_wb_wb_en,
    input  issue_pkg::reg_idx_t lsp_wb_dst,
    input  issue_pkg::xdata_t   lsp_wb_result,
    input  logic                lsp_mem_wb_en,
    input  issue_pkg::reg_idx_t lsp_mem_dst,
    // Issue slot state
    input  logic                ip_valid,
    input  logic                ip_ready,
    input  logic                ip_wb_en,
    input  issue_pkg::reg_idx_t ip_dst,
    input  logic                lsp_valid,
    input  logic                lsp_wb_en,
    input  issue_pkg::reg_idx_t lsp_dst,
    output issue_pkg::xdata_t   value,
    output logic                ready
);

    logic wb_buf_hit;
    logic ip_wb_hit;
    logic ip_ex_fwd;
    logic ip_ex_stall;
    logic lsp_wb_hit;
    logic lsp_mem_stall;
    logic lsp_ag_stall;

    assign wb_buf_hit    = wb_buf_valid && (wb_buf_dst == rsrc);
    assign ip_wb_hit     = ip_wb_valid && ip_wb_wb_en && (ip_wb_dst == rsrc);
    // Integer execute forwards only once its result is being accepted
    assign ip_ex_fwd     = ip_valid && ip_ready && ip_wb_en && (ip_dst == rsrc);
    assign ip_ex_stall   = ip_valid && !ip_ready && ip_wb_en && (ip_dst == rsrc);
    assign lsp_wb_hit    = lsp_wb_valid && lsp_wb_wb_en && (lsp_wb_dst == rsrc);
    assign lsp_mem_stall = lsp_mem_wb_en && (lsp_mem_dst == rsrc);
    assign lsp_ag_stall  = lsp_valid && lsp_wb_en && (lsp_dst == rsrc);

    // Oldest point first so younger producers win
    always_comb begin
        value = rdata;
        ready = 1'b1;
        if (wb_buf_hit) begin
            value = wb_buf_value;
        end
        if (ip_wb_hit) begin
            value = ip_wb_result;
        end
        if (ip_ex_fwd) begin
            value = ip_forwarding;
        end
        if (ip_ex_stall) begin
            ready = 1'b0;
        end
        if (lsp_wb_hit) begin
            value = lsp_wb_result;
            ready = 1'b1;
        end
        if (lsp_mem_stall || lsp_ag_stall) begin
            ready = 1'b0;
        end
        // x0 reads as zero even if some stage claims to write it
        if (rsrc == '0) begin
            value = '0;
            ready = 1'b1;
        end
    end

endmodule

// ==== issue_pkg.sv ====
package issue_pkg;

    // Datapath and register index widths
    localparam int XLEN = 64;
    localparam int REG_W = 5;

    // Load/store immediate offset width
    localparam int LSP_OFFSET_W = 12;

    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0] xdata_t;

    // First operand source
    typedef enum logic [1:0] {
        OPR1_RS1  = 2'd0,
        OPR1_PC   = 2'd1,
        OPR1_ZERO = 2'd2,
        OPR1_ZIMM = 2'd3    // rs1 field, zero-extended
    } opr1_sel_t;

    // Second operand source, code 3 is unused
    typedef enum logic [1:0] {
        OPR2_RS2  = 2'd0,
        OPR2_IMM  = 2'd1,
        OPR2_FOUR = 2'd2
    } opr2_sel_t;

    // Op type, any other code never issues
    typedef enum logic [2:0] {
        OT_INT   = 3'd0,
        OT_LOAD  = 3'd1,
        OT_STORE = 3'd2
    } op_type_t;

    // Integer pipe request
    typedef struct packed {
        xdata_t     pc;
        reg_idx_t   dst;
        logic       wb_en;
        logic [3:0] op;
        logic       option;
        logic       truncate;
        xdata_t     operand1;
        xdata_t     operand2;
    } ip_req_t;

    // Load/store pipe request
    typedef struct packed {
        xdata_t                  pc;
        reg_idx_t                dst;
        logic                    wb_en;
        xdata_t                  base;
        logic [LSP_OFFSET_W-1:0] offset;
        xdata_t                  source;
        logic                    mem_sign;
        logic [1:0]              mem_width;
    } lsp_req_t;

endpackage
